// File: hdl/mixer_config.svh
// FM mixer configuration constants
`ifndef MIXER_CONFIG_SVH
`define MIXER_CONFIG_SVH

`define OP_OUT_WIDTH       13 // operator level width
`define SAMPLE_WIDTH       16 // output sample width
`define NUM_BANKS          2
`define CHANNELS_PER_BANK  9
`define OPS_PER_BANK       18
`define NUM_CHANNELS       18 // banks times channels per bank
`define OP_FRAME_LEN       36 // operators per frame, also initial credits
`define ACC_WIDTH          31 // channel value width plus headroom for 18 terms
`define NUM_FOUR_OP        6  // four-op capable channels, 3 per bank

`endif

// File: hdl/opl_op_pkg.sv
// Operator stream types
`include "mixer_config.svh"

package opl_op_pkg;

    // signed output level of one operator
    typedef logic signed [`OP_OUT_WIDTH-1:0] op_level_t;

    // slot within a stored frame, bank*18 + op
    typedef logic [$clog2(`OP_FRAME_LEN)-1:0] op_slot_t;

    // one beat of the operator stream
    typedef struct packed {
        logic      valid;
        op_level_t level;
    } op_beat_t;

    // whole frame, slot 0 in the low bits
    typedef op_level_t [`OP_FRAME_LEN-1:0] op_frame_t;

endpackage

// File: hdl/opl_mix_pkg.sv
// Channel mixing types
`include "mixer_config.svh"

package opl_mix_pkg;

    typedef logic [$clog2(`CHANNELS_PER_BANK)-1:0] chan_index_t; // channel within a bank

    // operator width plus 2, holds a three operator sum
    typedef logic signed [`OP_OUT_WIDTH+1:0] chan_value_t;

    typedef logic signed [`ACC_WIDTH-1:0]    acc_t;
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // bit 0 is output A, bit 3 is output D
    typedef logic [3:0] out_enable_t;

    // matches host data bits 4:0
    typedef struct packed {
        logic        cnt;    // connection bit
        out_enable_t enable;
    } chan_cfg_t;

    typedef logic [4:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        reg_data_t data;
    } reg_write_t;

    typedef enum logic [1:0] {
        MIX_IDLE,
        MIX_ACCUM,
        MIX_LATCH
    } mix_state_t;

    typedef struct packed {
        logic    valid;
        sample_t a;
        sample_t b;
        sample_t c;
        sample_t d;
    } mix_sample_t;

endpackage

// File: hdl/channel_regs.sv
// Channel configuration registers
`timescale 1ns/1ps
`include "mixer_config.svh"

module channel_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  opl_mix_pkg::reg_write_t reg_wr,
    output opl_mix_pkg::chan_cfg_t chan_cfg [`NUM_CHANNELS],
    output logic [`NUM_FOUR_OP-1:0] four_op_sel
);

    // channels live at 0..17, four-op selects right after them
    localparam opl_mix_pkg::reg_addr_t FOUR_OP_ADDR = 5'(`NUM_CHANNELS);

    localparam opl_mix_pkg::chan_cfg_t CFG_RESET = '{
        cnt:    1'b0,
        enable: 4'b1111
    };

    localparam int CFG_BITS = $bits(opl_mix_pkg::chan_cfg_t);

    logic cfg_hit;  // write lands on a channel register
    logic sel_hit;  // write lands on the four-op select register

    assign cfg_hit = reg_wr.valid && (reg_wr.addr < FOUR_OP_ADDR);
    assign sel_hit = reg_wr.valid && (reg_wr.addr == FOUR_OP_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_CHANNELS; i++) begin
                chan_cfg[i] <= CFG_RESET; // two-op, all outputs on
            end
        end else if (cfg_hit) begin
            chan_cfg[reg_wr.addr] <= opl_mix_pkg::chan_cfg_t'(reg_wr.data[CFG_BITS-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            four_op_sel <= '0;
        end else if (sel_hit) begin
            four_op_sel <= reg_wr.data[`NUM_FOUR_OP-1:0]; // bank*3 + ch
        end
    end

    // addresses above 18 fall through both decodes and are dropped

endmodule

// File: hdl/op_frame_buffer.sv
// Operator frame buffer with credit return
`timescale 1ns/1ps
`include "mixer_config.svh"

module op_frame_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  opl_op_pkg::op_beat_t   op_in,
    input  logic                   frame_done,
    output opl_op_pkg::op_frame_t  op_frame,
    output logic                   frame_full,
    output logic                   op_credit
);

    localparam int CREDIT_BITS = $clog2(`OP_FRAME_LEN + 1);

    // pointer one past the last slot means the frame is complete
    localparam opl_op_pkg::op_slot_t FRAME_END = 6'(`OP_FRAME_LEN);

    localparam logic [CREDIT_BITS-1:0] CREDIT_LOAD = CREDIT_BITS'(`OP_FRAME_LEN);

    opl_op_pkg::op_slot_t    slot_ptr;    // next slot to write
    logic [CREDIT_BITS-1:0]  credit_cnt;  // credits still to hand back
    logic                    beat_accept;

    assign frame_full  = (slot_ptr == FRAME_END);
    assign beat_accept = op_in.valid && !frame_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_ptr <= '0;
        end else if (frame_done) begin
            slot_ptr <= '0; // rewind for next frame
        end else if (beat_accept) begin
            slot_ptr <= slot_ptr + 1'b1;
        end
    end

    // frame storage
    always_ff @(posedge clk) begin
        if (beat_accept) begin
            op_frame[slot_ptr] <= op_in.level;
        end
    end

    // the sender starts with a full window, so nothing is owed after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= '0;
        end else if (frame_done) begin
            credit_cnt <= CREDIT_LOAD;
        end else if (credit_cnt != '0) begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    assign op_credit = (credit_cnt != '0); // one credit per cycle

endmodule

// File: hdl/channel_algorithm.sv
// Two and four operator channel connection
`timescale 1ns/1ps
`include "mixer_config.svh"

module channel_algorithm (
    input  opl_op_pkg::op_frame_t    op_frame,
    input  logic                     bank,
    input  opl_mix_pkg::chan_index_t channel,
    input  opl_mix_pkg::chan_cfg_t   chan_cfg [`NUM_CHANNELS],
    input  logic [`NUM_FOUR_OP-1:0]  four_op_sel,
    output opl_mix_pkg::chan_value_t value
);

    int unsigned m_idx;     // first operator slot
    int unsigned cfg_idx;   // bank*9 + ch
    int unsigned sel_idx;   // bank*3 + ch

    logic four_op;          // channel 0..2 paired with ch+3
    logic pair_cnt;         // cnt of the partner channel

    opl_op_pkg::op_level_t   lvl_m, lvl_k, lvl_m2, lvl_k2;
    opl_mix_pkg::chan_value_t ext_m, ext_k, ext_m2, ext_k2;

    always_comb begin
        m_idx   = (bank ? `OPS_PER_BANK : 0) + 6 * (int'(channel) / 3) + int'(channel) % 3;
        cfg_idx = (bank ? `CHANNELS_PER_BANK : 0) + int'(channel);
        sel_idx = (bank ? 3 : 0) + int'(channel) % 3;

        lvl_m  = op_frame[m_idx];
        lvl_k  = op_frame[m_idx + 3];
        lvl_m2 = '0;
        lvl_k2 = '0;

        four_op  = 1'b0;
        pair_cnt = 1'b0;
        if (channel < 4'd3) begin // partner operators are m+6 and m+9
            four_op  = four_op_sel[sel_idx];
            pair_cnt = chan_cfg[cfg_idx + 3].cnt;
            lvl_m2   = op_frame[m_idx + 6];
            lvl_k2   = op_frame[m_idx + 9];
        end

        ext_m  = lvl_m; // sign extension
        ext_k  = lvl_k;
        ext_m2 = lvl_m2;
        ext_k2 = lvl_k2;

        if (four_op) begin
            unique case ({chan_cfg[cfg_idx].cnt, pair_cnt})
                2'b00:   value = ext_k2;
                2'b01:   value = ext_k + ext_k2;
                2'b10:   value = ext_m + ext_k2;
                default: value = ext_m + ext_m2 + ext_k2;
            endcase
        end else begin
            value = chan_cfg[cfg_idx].cnt ? ext_m + ext_k : ext_k;
        end
    end

endmodule

// File: hdl/channel_mixer.sv
// Channel sequencer, accumulators and clamp
`timescale 1ns/1ps
`include "mixer_config.svh"

module channel_mixer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     frame_full,
    input  opl_mix_pkg::chan_value_t value,
    input  opl_mix_pkg::chan_cfg_t   chan_cfg [`NUM_CHANNELS],
    output logic                     bank,
    output opl_mix_pkg::chan_index_t channel,
    output logic                     frame_done,
    output opl_mix_pkg::mix_sample_t mix_out
);

    localparam int NUM_OUTPUTS = $bits(opl_mix_pkg::out_enable_t);

    localparam opl_mix_pkg::chan_index_t LAST_CHAN = 4'(`CHANNELS_PER_BANK - 1);

    localparam opl_mix_pkg::acc_t SAMPLE_MAX = `ACC_WIDTH'((1 << (`SAMPLE_WIDTH - 1)) - 1);
    localparam opl_mix_pkg::acc_t SAMPLE_MIN = `ACC_WIDTH'(-(1 << (`SAMPLE_WIDTH - 1)));

    opl_mix_pkg::mix_state_t  state;
    opl_mix_pkg::acc_t        acc [NUM_OUTPUTS]; // A, B, C, D sums
    opl_mix_pkg::out_enable_t cur_enable;
    opl_mix_pkg::acc_t        value_ext;
    logic                     last_chan;

    function automatic opl_mix_pkg::sample_t clamp(input opl_mix_pkg::acc_t sum);
        opl_mix_pkg::acc_t limited;
        if (sum > SAMPLE_MAX) begin
            limited = SAMPLE_MAX;
        end else if (sum < SAMPLE_MIN) begin
            limited = SAMPLE_MIN;
        end else begin
            limited = sum;
        end
        return opl_mix_pkg::sample_t'(limited);
    endfunction

    assign cur_enable = chan_cfg[(bank ? `CHANNELS_PER_BANK : 0) + int'(channel)].enable;
    assign value_ext  = value; // sign extension to accumulator width
    assign last_chan  = (channel == LAST_CHAN);
    assign frame_done = (state == opl_mix_pkg::MIX_LATCH);

    // walk bank 0 then bank 1, channels 0 to 8
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= opl_mix_pkg::MIX_IDLE;
            bank    <= 1'b0;
            channel <= '0;
        end else begin
            unique case (state)
                opl_mix_pkg::MIX_IDLE: begin
                    if (frame_full) begin
                        state <= opl_mix_pkg::MIX_ACCUM;
                    end
                end
                opl_mix_pkg::MIX_ACCUM: begin
                    if (last_chan) begin
                        channel <= '0;
                        bank    <= ~bank; // back to bank 0 after the last channel
                    end else begin
                        channel <= channel + 1'b1;
                    end
                    if (bank && last_chan) begin
                        state <= opl_mix_pkg::MIX_LATCH;
                    end
                end
                default: begin
                    state <= opl_mix_pkg::MIX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || state == opl_mix_pkg::MIX_LATCH) begin
            for (int i = 0; i < NUM_OUTPUTS; i++) begin
                acc[i] <= '0; // sums restart each frame
            end
        end else if (state == opl_mix_pkg::MIX_ACCUM) begin
            for (int i = 0; i < NUM_OUTPUTS; i++) begin
                if (cur_enable[i]) begin
                    acc[i] <= acc[i] + value_ext;
                end
            end
        end
    end

    // samples hold until the next latch
    always_ff @(posedge clk) begin
        if (reset) begin
            mix_out <= '0;
        end else if (state == opl_mix_pkg::MIX_LATCH) begin
            mix_out.valid <= 1'b1;
            mix_out.a     <= clamp(acc[0]);
            mix_out.b     <= clamp(acc[1]);
            mix_out.c     <= clamp(acc[2]);
            mix_out.d     <= clamp(acc[3]);
        end else begin
            mix_out.valid <= 1'b0; // single cycle pulse
        end
    end

endmodule

// File: hdl/mixer_top.sv
// FM channel mixer top level
`timescale 1ns/1ps
`include "mixer_config.svh"

module mixer_top (
    input  logic                     clk,
    input  logic                     reset,
    input  opl_op_pkg::op_beat_t     op_in,
    output logic                     op_credit,
    input  opl_mix_pkg::reg_write_t  reg_wr,
    output opl_mix_pkg::mix_sample_t mix_out
);

    opl_mix_pkg::chan_cfg_t   chan_cfg [`NUM_CHANNELS];
    logic [`NUM_FOUR_OP-1:0]  four_op_sel;
    opl_op_pkg::op_frame_t    op_frame;
    logic                     frame_full;
    logic                     frame_done;
    logic                     bank;
    opl_mix_pkg::chan_index_t channel;
    opl_mix_pkg::chan_value_t value;

    channel_regs u_channel_regs (
        .clk         (clk),
        .reset       (reset),
        .reg_wr      (reg_wr),
        .chan_cfg    (chan_cfg),
        .four_op_sel (four_op_sel)
    );

    op_frame_buffer u_op_frame_buffer (
        .clk        (clk),
        .reset      (reset),
        .op_in      (op_in),
        .frame_done (frame_done),
        .op_frame   (op_frame),
        .frame_full (frame_full),
        .op_credit  (op_credit)
    );

    channel_algorithm u_channel_algorithm (
        .op_frame    (op_frame),
        .bank        (bank),
        .channel     (channel),
        .chan_cfg    (chan_cfg),
        .four_op_sel (four_op_sel),
        .value       (value)
    );

    channel_mixer u_channel_mixer (
        .clk        (clk),
        .reset      (reset),
        .frame_full (frame_full),
        .value      (value),
        .chan_cfg   (chan_cfg),
        .bank       (bank),
        .channel    (channel),
        .frame_done (frame_done),
        .mix_out    (mix_out)
    );

endmodule

// File: dv/mixer_props.sv
// Mixer protocol assertions
`timescale 1ns/1ps
`include "mixer_config.svh"

module mixer_props (
    input logic                     clk,
    input logic                     reset,
    input opl_op_pkg::op_beat_t     op_in,
    input logic                     op_credit,
    input logic                     frame_full,
    input opl_mix_pkg::mix_sample_t mix_out
);

    int owed; // beats sent minus credits handed back

    always_ff @(posedge clk) begin
        if (reset) begin
            owed <= 0;
        end else begin
            owed <= owed + int'(op_in.valid) - int'(op_credit);
        end
    end

    single_valid: assert property (
        @(posedge clk) disable iff (reset)
        mix_out.valid |=> !mix_out.valid
    ) else $error("mix_out.valid stayed high for more than one cycle");

    no_beat_when_full: assert property (
        @(posedge clk) disable iff (reset)
        op_in.valid |-> !frame_full
    ) else $error("operator beat arrived while the frame buffer was full");

    credit_bound: assert property (
        @(posedge clk) disable iff (reset)
        (owed >= 0) && (owed <= `OP_FRAME_LEN)
    ) else $error("outstanding credits out of range: %0d", owed);

endmodule

// File: dv/mixer_tb.sv
// FM mixer testbench
`timescale 1ns/1ps
`include "mixer_config.svh"

module mixer_tb;

    localparam int NUM_ENTRIES    = 9;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 120;
    localparam int SAMPLE_MAX     = 32767;
    localparam int SAMPLE_MIN     = -32768;

    logic                     clk;
    logic                     reset;
    opl_op_pkg::op_beat_t     op_in;
    logic                     op_credit;
    opl_mix_pkg::reg_write_t  reg_wr;
    opl_mix_pkg::mix_sample_t mix_out;

    logic [4:0] cfg_tab [NUM_ENTRIES][`NUM_CHANNELS]; // {cnt, enable D..A}
    logic [5:0] sel_tab [NUM_ENTRIES];                // four-op selects, bank*3 + ch
    int         mode_tab [NUM_ENTRIES];               // 0 small, 1 near max, 2 near min
    bit         b2b_tab [NUM_ENTRIES];                // keep config, send at once
    int         exp_tab [NUM_ENTRIES][4];             // expected A..D

    int levels [`OP_FRAME_LEN];
    int returned;      // credit pulses seen
    int sent_total;    // beats driven
    int valid_count;
    int cycle_count;

    mixer_top u_mixer_top (
        .clk       (clk),
        .reset     (reset),
        .op_in     (op_in),
        .op_credit (op_credit),
        .reg_wr    (reg_wr),
        .mix_out   (mix_out)
    );

    bind mixer_top mixer_props u_mixer_props (
        .clk        (clk),
        .reset      (reset),
        .op_in      (op_in),
        .op_credit  (op_credit),
        .frame_full (frame_full),
        .mix_out    (mix_out)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "run stopped at the cycle limit");
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            returned    <= 0;
            valid_count <= 0;
        end else begin
            if (op_credit) returned <= returned + 1;
            if (mix_out.valid) valid_count <= valid_count + 1;
        end
    end

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            $display("Checks failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic int first_op(input int c);
        return 6 * (c / 3) + c % 3;
    endfunction

    function automatic int clamp_sample(input int sum);
        if (sum > SAMPLE_MAX) return SAMPLE_MAX;
        if (sum < SAMPLE_MIN) return SAMPLE_MIN;
        return sum;
    endfunction

    // connection rule for one channel of one bank
    function automatic int channel_value(input int e, input int b, input int c);
        int   m;
        int   k;
        int   m2;
        int   k2;
        int   result;
        logic cnt_own;
        logic cnt_pair;
        m       = b * `OPS_PER_BANK + first_op(c);
        k       = m + 3;
        cnt_own = cfg_tab[e][b * `CHANNELS_PER_BANK + c][4];
        result  = cnt_own ? levels[m] + levels[k] : levels[k];
        if (c < 3 && sel_tab[e][b * 3 + c]) begin
            m2       = b * `OPS_PER_BANK + first_op(c + 3);
            k2       = m2 + 3;
            cnt_pair = cfg_tab[e][b * `CHANNELS_PER_BANK + c + 3][4];
            case ({cnt_own, cnt_pair})
                2'b00:   result = levels[k2];
                2'b01:   result = levels[k] + levels[k2];
                2'b10:   result = levels[m] + levels[k2];
                default: result = levels[m] + levels[m2] + levels[k2];
            endcase
        end
        return result;
    endfunction

    task automatic compute_expected(input int e);
        int sum;
        for (int out = 0; out < 4; out++) begin
            sum = 0;
            for (int i = 0; i < `NUM_CHANNELS; i++) begin
                if (cfg_tab[e][i][out]) sum += channel_value(e, i / 9, i % 9);
            end
            exp_tab[e][out] = clamp_sample(sum);
        end
    endtask

    task automatic build_table();
        logic [8:0] cnt_a;
        logic [8:0] cnt_b;
        cnt_a = 9'h014; // pairs 00, 01, 10 on channels 0..2
        cnt_b = 9'h02B; // pairs 11, 10, 01
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            cfg_tab[0][i] = {1'b0, 4'hf};
            cfg_tab[1][i] = {1'(i % 2), 4'hf};
            cfg_tab[2][i] = {(i < 9) ? cnt_a[i % 9] : cnt_b[i % 9], 4'hf};
            cfg_tab[3][i] = {(i < 9) ? cnt_b[i % 9] : cnt_a[i % 9], 4'hf};
            cfg_tab[4][i] = {1'((i % 3) == 0), 4'((i * 7 + 3) % 16)};
            cfg_tab[5][i] = cfg_tab[4][i];
            cfg_tab[6][i] = 5'b1_1111;
            cfg_tab[7][i] = 5'b1_1111;
            cfg_tab[8][i] = 5'b1_1111;
        end
        sel_tab = '{6'h00, 6'h00, 6'h3f, 6'b011_101, 6'h00, 6'h00, 6'h00, 6'h3f, 6'h3f};
        mode_tab = '{0, 0, 0, 0, 0, 0, 1, 2, 0};
        b2b_tab = '{0, 0, 0, 0, 0, 1, 0, 0, 1};
    endtask

    task automatic make_levels(input int e);
        for (int i = 0; i < `OP_FRAME_LEN; i++) begin
            case (mode_tab[e])
                1:       levels[i] = 4095 - int'($urandom_range(63));
                2:       levels[i] = -4096 + int'($urandom_range(63));
                default: levels[i] = int'($urandom_range(1022)) - 511;
            endcase
        end
    endtask

    task automatic write_reg(input int addr, input int data);
        @(posedge clk);
        reg_wr.valid <= 1'b1;
        reg_wr.addr  <= 5'(addr);
        reg_wr.data  <= 8'(data);
    endtask

    task automatic configure(input int e);
        for (int i = 0; i < `NUM_CHANNELS; i++) begin
            write_reg(i, int'(cfg_tab[e][i]));
        end
        write_reg(`NUM_CHANNELS, int'(sel_tab[e]));
        @(posedge clk);
        reg_wr.valid <= 1'b0;
    endtask

    // one beat per cycle while a credit is held
    task automatic send_frame();
        int idx;
        int avail;
        idx = 0;
        while (idx < `OP_FRAME_LEN) begin
            @(posedge clk);
            avail = `OP_FRAME_LEN + returned + int'(op_credit) - sent_total;
            if (avail > 0) begin
                op_in.valid <= 1'b1;
                op_in.level <= opl_op_pkg::op_level_t'(levels[idx]);
                sent_total++;
                idx++;
            end else begin
                op_in.valid <= 1'b0;
            end
        end
        @(posedge clk);
        op_in.valid <= 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        op_in       = '0;
        reg_wr      = '0;
        cycle_count = 0;
        sent_total  = 0;
        void'($urandom(32'hf8e8_ad5c));
        build_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (!b2b_tab[e]) configure(e);
            make_levels(e);
            compute_expected(e);
            send_frame();
            @(posedge clk);
            while (!mix_out.valid) @(posedge clk);
            check_value("mix_out.a", int'(mix_out.a), exp_tab[e][0]);
            check_value("mix_out.b", int'(mix_out.b), exp_tab[e][1]);
            check_value("mix_out.c", int'(mix_out.c), exp_tab[e][2]);
            check_value("mix_out.d", int'(mix_out.d), exp_tab[e][3]);
            @(posedge clk);
            check_value("mix_out.valid pulses", valid_count, e + 1);
        end

        // every credit should come home after the last frame
        while (returned < sent_total) @(posedge clk);
        @(posedge clk);
        check_value("credits returned", returned, NUM_ENTRIES * `OP_FRAME_LEN);
        check_value("op_credit", int'(op_credit), 0);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+hdl
hdl/opl_op_pkg.sv
hdl/opl_mix_pkg.sv
hdl/channel_regs.sv
hdl/op_frame_buffer.sv
hdl/channel_algorithm.sv
hdl/channel_mixer.sv
hdl/mixer_top.sv
dv/mixer_props.sv
dv/mixer_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module mixer_tb -o mixer_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mixer_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
